//--- ninjin_pkg.sv
`default_nettype none

package ninjin_pkg;

  // compute word and ddr beat widths.
  localparam int DWIDTH    = 16;
  localparam int BWIDTH    = 32;
  localparam int RATE      = BWIDTH / DWIDTH;

  // one bank holds one burst.
  localparam int BURST_LEN = 8;
  localparam int BAWIDTH   = $clog2(BURST_LEN);
  localparam int BCWIDTH   = BAWIDTH + 1;
  localparam int NBANK     = 2;

  localparam int MEMSIZE   = 16;
  localparam int LWIDTH    = 16;

  // axi4-lite register window.
  localparam int AXI_AWIDTH = 8;
  localparam int AXI_DWIDTH = 32;

  localparam logic [AXI_AWIDTH-1:0] REG_CTRL   = 8'h00;
  localparam logic [AXI_AWIDTH-1:0] REG_BASE   = 8'h04;
  localparam logic [AXI_AWIDTH-1:0] REG_LEN    = 8'h08;
  localparam logic [AXI_AWIDTH-1:0] REG_STATUS = 8'h0c;

  // base in beats, length in words.
  typedef struct packed {
    logic [MEMSIZE-1:0] base;
    logic [LWIDTH-1:0]  total_len;
  } job_t;

  typedef struct packed {
    logic               bank;
    logic [BCWIDTH-1:0] beats;
    logic [MEMSIZE-1:0] offset;
    logic               last;
  } burst_t;

  typedef struct packed {
    logic               we;
    logic [BAWIDTH-1:0] addr;
    logic [BWIDTH-1:0]  data;
  } bank_wr_t;

endpackage

`default_nettype wire

//--- ninjin_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_bank #(
  parameter int BWIDTH    = ninjin_pkg::BWIDTH,
  parameter int BURST_LEN = ninjin_pkg::BURST_LEN
) (
  input  logic                         clk,
  input  ninjin_pkg::bank_wr_t         wr,
  input  logic [$clog2(BURST_LEN)-1:0] rd_addr,
  output logic [BWIDTH-1:0]            rd_data
);

  logic [BWIDTH-1:0] mem [BURST_LEN];

  // one write port from the packer.
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read for the drain.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- ninjin_ctrl_lite.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_ctrl_lite (
  input  logic                                  clk,
  input  logic                                  xrst,
  input  logic [ninjin_pkg::AXI_AWIDTH-1:0]     s_axi_awaddr,
  input  logic                                  s_axi_awvalid,
  output logic                                  s_axi_awready,
  input  logic [ninjin_pkg::AXI_DWIDTH-1:0]     s_axi_wdata,
  input  logic [ninjin_pkg::AXI_DWIDTH/8-1:0]   s_axi_wstrb,
  input  logic                                  s_axi_wvalid,
  output logic                                  s_axi_wready,
  output logic [1:0]                            s_axi_bresp,
  output logic                                  s_axi_bvalid,
  input  logic                                  s_axi_bready,
  input  logic [ninjin_pkg::AXI_AWIDTH-1:0]     s_axi_araddr,
  input  logic                                  s_axi_arvalid,
  output logic                                  s_axi_arready,
  output logic [ninjin_pkg::AXI_DWIDTH-1:0]     s_axi_rdata,
  output logic [1:0]                            s_axi_rresp,
  output logic                                  s_axi_rvalid,
  input  logic                                  s_axi_rready,
  output ninjin_pkg::job_t                      job,
  output logic                                  start,
  input  logic                                  job_done
);
  import ninjin_pkg::*;

  logic                  wr_en;
  logic                  rd_en;
  logic                  start_wr;
  logic                  busy;
  logic                  done;
  logic [AXI_DWIDTH-1:0] base_next;
  logic [AXI_DWIDTH-1:0] len_next;

  // byte lanes of a register write.
  function automatic logic [AXI_DWIDTH-1:0] merge_strb(
    input logic [AXI_DWIDTH-1:0]   old_val,
    input logic [AXI_DWIDTH-1:0]   new_val,
    input logic [AXI_DWIDTH/8-1:0] strb
  );
    logic [AXI_DWIDTH-1:0] res;
    for (int i = 0; i < AXI_DWIDTH / 8; i++) begin
      res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return res;
  endfunction

  // ########################################################################
  // handshakes.
  // ########################################################################

  // address and data are taken together.
  assign wr_en         = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign rd_en         = s_axi_arvalid & ~s_axi_rvalid;
  assign s_axi_awready = wr_en;
  assign s_axi_wready  = wr_en;
  assign s_axi_arready = rd_en;
  assign s_axi_bresp   = 2'b00;
  assign s_axi_rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      s_axi_bvalid <= 1'b0;
    end else if (wr_en) begin
      s_axi_bvalid <= 1'b1;
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_en) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // ########################################################################
  // registers.
  // ########################################################################

  assign base_next = merge_strb(AXI_DWIDTH'(job.base), s_axi_wdata, s_axi_wstrb);
  assign len_next  = merge_strb(AXI_DWIDTH'(job.total_len), s_axi_wdata, s_axi_wstrb);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      job <= '0;
    end else if (wr_en) begin
      case (s_axi_awaddr)
        REG_BASE: job.base      <= MEMSIZE'(base_next);
        REG_LEN:  job.total_len <= LWIDTH'(len_next);
        default: ;
      endcase
    end
  end

  // a start while busy is dropped.
  assign start_wr = wr_en && s_axi_awaddr == REG_CTRL && s_axi_wstrb[0]
                    && s_axi_wdata[0] && !busy;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start <= 1'b0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      start <= start_wr;
      if (start_wr) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (job_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      case (s_axi_araddr)
        REG_BASE:   s_axi_rdata <= AXI_DWIDTH'(job.base);
        REG_LEN:    s_axi_rdata <= AXI_DWIDTH'(job.total_len);
        REG_STATUS: s_axi_rdata <= AXI_DWIDTH'({done, busy});
        default:    s_axi_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- ninjin_pack.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_pack #(
  parameter int DWIDTH    = ninjin_pkg::DWIDTH,
  parameter int BWIDTH    = ninjin_pkg::BWIDTH,
  parameter int BURST_LEN = ninjin_pkg::BURST_LEN,
  parameter int MEMSIZE   = ninjin_pkg::MEMSIZE
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  ninjin_pkg::job_t         job,
  input  logic                     start,
  input  logic                     mem_we,
  input  logic signed [DWIDTH-1:0] mem_wdata,
  output logic                     mem_ready,
  output ninjin_pkg::bank_wr_t     bank_wr [ninjin_pkg::NBANK],
  output ninjin_pkg::burst_t       burst,
  output logic                     burst_valid,
  input  logic                     burst_ready,
  input  logic                     bank_release,
  input  logic                     release_bank
);
  import ninjin_pkg::*;

  localparam int RATE = BWIDTH / DWIDTH;
  localparam int AW   = $clog2(BURST_LEN);
  localparam int WCW  = (RATE > 1) ? $clog2(RATE) : 1;

  logic signed [DWIDTH-1:0] chain [RATE];
  logic [BWIDTH-1:0]        beat;
  logic [WCW-1:0]           word_cnt;
  logic [AW-1:0]            beat_cnt;
  logic [LWIDTH-1:0]        words_left;
  logic [MEMSIZE-1:0]       beat_off;
  logic [NBANK-1:0]         full;
  logic                     fill_bank;
  logic                     beat_done;
  logic                     closing;
  logic                     accept;

  // ########################################################################
  // word side.
  // ########################################################################

  // the beat written now closes the fill bank.
  assign closing   = beat_done && (beat_cnt == AW'(BURST_LEN - 1) || words_left == '0);
  assign mem_ready = words_left != '0 && !full[fill_bank] && !burst_valid && !closing;
  assign accept    = mem_we & mem_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      chain[0] <= mem_wdata;
      for (int i = 1; i < RATE; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // oldest word in the low half.
  always_comb begin
    for (int i = 0; i < RATE; i++) begin
      beat[i*DWIDTH +: DWIDTH] = chain[RATE-1-i];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      words_left <= '0;
      word_cnt   <= '0;
      beat_done  <= 1'b0;
    end else begin
      beat_done <= accept && word_cnt == WCW'(RATE - 1);
      if (start) begin
        words_left <= job.total_len;
        word_cnt   <= '0;
      end else if (accept) begin
        words_left <= words_left - 1'b1;
        word_cnt   <= (word_cnt == WCW'(RATE - 1)) ? '0 : word_cnt + 1'b1;
      end
    end
  end

  // ########################################################################
  // bank side.
  // ########################################################################

  always_comb begin
    for (int b = 0; b < NBANK; b++) begin
      bank_wr[b].we   = beat_done && fill_bank == 1'(b);
      bank_wr[b].addr = beat_cnt;
      bank_wr[b].data = beat;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      beat_cnt    <= '0;
      beat_off    <= '0;
      fill_bank   <= 1'b0;
      full        <= '0;
      burst_valid <= 1'b0;
    end else begin
      if (burst_valid && burst_ready) begin
        burst_valid <= 1'b0;
      end
      if (bank_release) begin
        full[release_bank] <= 1'b0;
      end
      if (start) begin
        beat_cnt  <= '0;
        beat_off  <= '0;
        fill_bank <= 1'b0;
      end else if (closing) begin
        full[fill_bank] <= 1'b1;
        burst_valid     <= 1'b1;
        fill_bank       <= ~fill_bank;
        beat_cnt        <= '0;
        beat_off        <= beat_off + MEMSIZE'(beat_cnt) + 1'b1;
      end else if (beat_done) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // burst descriptor for the drain.
  always_ff @(posedge clk) begin
    if (closing) begin
      burst.bank   <= fill_bank;
      burst.beats  <= BCWIDTH'(beat_cnt) + 1'b1;
      burst.offset <= beat_off;
      burst.last   <= words_left == '0;
    end
  end

endmodule

`default_nettype wire

//--- ninjin_ddr_drain.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_ddr_drain #(
  parameter int BWIDTH    = ninjin_pkg::BWIDTH,
  parameter int BURST_LEN = ninjin_pkg::BURST_LEN,
  parameter int MEMSIZE   = ninjin_pkg::MEMSIZE
) (
  input  logic                         clk,
  input  logic                         xrst,
  input  ninjin_pkg::job_t             job,
  input  logic                         start,
  input  ninjin_pkg::burst_t           burst,
  input  logic                         burst_valid,
  output logic                         burst_ready,
  output logic [$clog2(BURST_LEN)-1:0] rd_addr,
  input  logic [BWIDTH-1:0]            rd_data [ninjin_pkg::NBANK],
  output logic                         bank_release,
  output logic                         release_bank,
  output logic                         job_done,
  output logic                         ddr_we,
  output logic [MEMSIZE-1:0]           ddr_addr,
  output logic [BWIDTH-1:0]            ddr_wdata,
  input  logic                         ddr_ready
);
  import ninjin_pkg::*;

  localparam int AW = $clog2(BURST_LEN);

  burst_t             cur;
  logic [MEMSIZE-1:0] base;
  logic [AW:0]        rd_ptr;
  logic [AW:0]        out_cnt;
  logic [BWIDTH-1:0]  hold_data;
  logic               run;
  logic               rd_vld;
  logic               hold_vld;
  logic               take;
  logic               issue;
  logic               xfer;

  // ########################################################################
  // handoff and read issue.
  // ########################################################################

  assign burst_ready = ~run;
  assign take        = burst_valid & ~run;
  assign xfer        = ddr_we & ddr_ready;

  // read ahead only when the beat slot frees up this cycle.
  assign issue   = run && rd_ptr < cur.beats && (!ddr_we || ddr_ready);
  assign rd_addr = rd_ptr[AW-1:0];

  // ########################################################################
  // ddr side.
  // ########################################################################

  assign ddr_we       = rd_vld | hold_vld;
  assign ddr_wdata    = hold_vld ? hold_data : rd_data[cur.bank];
  assign release_bank = cur.bank;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      run          <= 1'b0;
      rd_vld       <= 1'b0;
      hold_vld     <= 1'b0;
      bank_release <= 1'b0;
      job_done     <= 1'b0;
    end else begin
      rd_vld       <= issue;
      bank_release <= 1'b0;
      job_done     <= 1'b0;
      if (ddr_ready) begin
        hold_vld <= 1'b0;
      end else if (rd_vld) begin
        hold_vld <= 1'b1;
      end
      if (take) begin
        run <= 1'b1;
      end else if (xfer && out_cnt == cur.beats - 1'b1) begin
        run          <= 1'b0;
        bank_release <= 1'b1;
        job_done     <= cur.last;
      end
    end
  end

  // bank data is gone one cycle later, so keep it.
  always_ff @(posedge clk) begin
    if (rd_vld && !ddr_ready) begin
      hold_data <= rd_data[cur.bank];
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      base <= job.base;
    end
    if (take) begin
      cur      <= burst;
      rd_ptr   <= '0;
      out_cnt  <= '0;
      ddr_addr <= base + burst.offset;
    end else begin
      if (issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (xfer) begin
        out_cnt  <= out_cnt + 1'b1;
        ddr_addr <= ddr_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- ninjin_ddr_buf.sv
`timescale 1ns/1ps
`default_nettype none

module ninjin_ddr_buf #(
  parameter int DWIDTH    = ninjin_pkg::DWIDTH,
  parameter int BWIDTH    = ninjin_pkg::BWIDTH,
  parameter int BURST_LEN = ninjin_pkg::BURST_LEN,
  parameter int MEMSIZE   = ninjin_pkg::MEMSIZE
) (
  input  logic                                clk,
  input  logic                                xrst,
  input  logic [ninjin_pkg::AXI_AWIDTH-1:0]   s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  input  logic [ninjin_pkg::AXI_DWIDTH-1:0]   s_axi_wdata,
  input  logic [ninjin_pkg::AXI_DWIDTH/8-1:0] s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  output logic [1:0]                          s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  input  logic [ninjin_pkg::AXI_AWIDTH-1:0]   s_axi_araddr,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  output logic [ninjin_pkg::AXI_DWIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                          s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  input  logic                                mem_we,
  input  logic signed [DWIDTH-1:0]            mem_wdata,
  output logic                                mem_ready,
  output logic                                ddr_we,
  output logic [MEMSIZE-1:0]                  ddr_addr,
  output logic [BWIDTH-1:0]                   ddr_wdata,
  input  logic                                ddr_ready
);
  import ninjin_pkg::*;

  job_t                         job;
  logic                         start;
  logic                         job_done;
  bank_wr_t                     bank_wr [NBANK];
  burst_t                       burst;
  logic                         burst_valid;
  logic                         burst_ready;
  logic                         bank_release;
  logic                         release_bank;
  logic [$clog2(BURST_LEN)-1:0] rd_addr;
  logic [BWIDTH-1:0]            rd_data [NBANK];

  ninjin_ctrl_lite i_ctrl (
    .clk           (clk),
    .xrst          (xrst),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .job           (job),
    .start         (start),
    .job_done      (job_done)
  );

  ninjin_pack #(
    .DWIDTH    (DWIDTH),
    .BWIDTH    (BWIDTH),
    .BURST_LEN (BURST_LEN),
    .MEMSIZE   (MEMSIZE)
  ) i_pack (
    .clk          (clk),
    .xrst         (xrst),
    .job          (job),
    .start        (start),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .bank_wr      (bank_wr),
    .burst        (burst),
    .burst_valid  (burst_valid),
    .burst_ready  (burst_ready),
    .bank_release (bank_release),
    .release_bank (release_bank)
  );

  // ping-pong banks, roles swap every burst.
  for (genvar b = 0; b < NBANK; b++) begin : g_bank
    ninjin_bank #(
      .BWIDTH    (BWIDTH),
      .BURST_LEN (BURST_LEN)
    ) i_bank (
      .clk     (clk),
      .wr      (bank_wr[b]),
      .rd_addr (rd_addr),
      .rd_data (rd_data[b])
    );
  end

  ninjin_ddr_drain #(
    .BWIDTH    (BWIDTH),
    .BURST_LEN (BURST_LEN),
    .MEMSIZE   (MEMSIZE)
  ) i_drain (
    .clk          (clk),
    .xrst         (xrst),
    .job          (job),
    .start        (start),
    .burst        (burst),
    .burst_valid  (burst_valid),
    .burst_ready  (burst_ready),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .bank_release (bank_release),
    .release_bank (release_bank),
    .job_done     (job_done),
    .ddr_we       (ddr_we),
    .ddr_addr     (ddr_addr),
    .ddr_wdata    (ddr_wdata),
    .ddr_ready    (ddr_ready)
  );

endmodule

`default_nettype wire

//--- tb_ninjin_ddr_buf_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ninjin_ddr_buf_assert (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           ddr_we,
  input  logic                           ddr_ready,
  input  logic [ninjin_pkg::MEMSIZE-1:0] ddr_addr,
  input  logic [ninjin_pkg::BWIDTH-1:0]  ddr_wdata,
  input  logic                           s_axi_bvalid,
  input  logic                           s_axi_bready,
  input  logic                           s_axi_rvalid,
  input  logic                           s_axi_rready,
  input  logic                           mem_ready
);

  // read by the testbench at the end of the run.
  int unsigned fail_cnt = 0;

  // a stalled beat keeps its address and data.
  property ddr_hold;
    @(posedge clk) disable iff (!xrst)
      ddr_we && !ddr_ready |=> ddr_we && $stable(ddr_addr) && $stable(ddr_wdata);
  endproperty

  property bvalid_hold;
    @(posedge clk) disable iff (!xrst)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid;
  endproperty

  property rvalid_hold;
    @(posedge clk) disable iff (!xrst)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid;
  endproperty

  // outputs idle while in reset.
  property reset_idle;
    @(posedge clk) !xrst |=> !mem_ready && !ddr_we && !s_axi_bvalid && !s_axi_rvalid;
  endproperty

  a_ddr_hold: assert property (ddr_hold) else begin
    fail_cnt++;
    $error("ddr beat changed while ddr_ready was low");
  end

  a_bvalid_hold: assert property (bvalid_hold) else begin
    fail_cnt++;
    $error("bvalid dropped before bready");
  end

  a_rvalid_hold: assert property (rvalid_hold) else begin
    fail_cnt++;
    $error("rvalid dropped before rready");
  end

  a_reset_idle: assert property (reset_idle) else begin
    fail_cnt++;
    $error("output active during reset");
  end

endmodule

bind ninjin_ddr_buf tb_ninjin_ddr_buf_assert i_assert (
  .clk          (clk),
  .xrst         (xrst),
  .ddr_we       (ddr_we),
  .ddr_ready    (ddr_ready),
  .ddr_addr     (ddr_addr),
  .ddr_wdata    (ddr_wdata),
  .s_axi_bvalid (s_axi_bvalid),
  .s_axi_bready (s_axi_bready),
  .s_axi_rvalid (s_axi_rvalid),
  .s_axi_rready (s_axi_rready),
  .mem_ready    (mem_ready)
);

`default_nettype wire

//--- tb_ninjin_ddr_buf.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ninjin_ddr_buf;
  import ninjin_pkg::*;

  localparam int TIMEOUT    = 2000;
  localparam int POLL_LIMIT = 500;
  localparam int READY_HIGH = 0;
  localparam int READY_RAND = 1;
  localparam int READY_LOW  = 2;
  localparam int NADDR      = 1 << MEMSIZE;

  logic                      clk;
  logic                      xrst;
  logic [AXI_AWIDTH-1:0]     s_axi_awaddr;
  logic                      s_axi_awvalid;
  logic                      s_axi_awready;
  logic [AXI_DWIDTH-1:0]     s_axi_wdata;
  logic [AXI_DWIDTH/8-1:0]   s_axi_wstrb;
  logic                      s_axi_wvalid;
  logic                      s_axi_wready;
  logic [1:0]                s_axi_bresp;
  logic                      s_axi_bvalid;
  logic                      s_axi_bready;
  logic [AXI_AWIDTH-1:0]     s_axi_araddr;
  logic                      s_axi_arvalid;
  logic                      s_axi_arready;
  logic [AXI_DWIDTH-1:0]     s_axi_rdata;
  logic [1:0]                s_axi_rresp;
  logic                      s_axi_rvalid;
  logic                      s_axi_rready;
  logic                      mem_we;
  logic signed [DWIDTH-1:0]  mem_wdata;
  logic                      mem_ready;
  logic                      ddr_we;
  logic [MEMSIZE-1:0]        ddr_addr;
  logic [BWIDTH-1:0]         ddr_wdata;
  logic                      ddr_ready;

  // ddr model state.
  logic [BWIDTH-1:0]         ddr_mem [NADDR];
  logic                      ddr_written [NADDR];
  int                        ddr_beats;
  int                        ready_mode;
  int                        rnd;
  integer                    seed = 32'hb912;

  ninjin_ddr_buf i_ninjin_ddr_buf (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    rnd = $random(seed);
    case (ready_mode)
      READY_RAND: ddr_ready <= rnd[0];
      READY_LOW:  ddr_ready <= 1'b0;
      default:    ddr_ready <= 1'b1;
    endcase
  end

  always @(posedge clk) begin
    if (xrst && ddr_we && ddr_ready) begin
      ddr_mem[ddr_addr]     <= ddr_wdata;
      ddr_written[ddr_addr] <= 1'b1;
      ddr_beats             <= ddr_beats + 1;
    end
  end

  // ########################################################################
  // helpers.
  // ########################################################################

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic expect_equal(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %h actual %h", test, what, exp, act);
      abort_run();
    end
  endtask

  // word i of a job, tag keeps jobs apart.
  function automatic logic [DWIDTH-1:0] word_value(input int tag, input int idx);
    return DWIDTH'(tag * 32'h0f1 + idx * 32'h2b3 + 32'h8000);
  endfunction

  // low word first.
  function automatic logic [BWIDTH-1:0] beat_value(input int tag, input int k);
    logic [BWIDTH-1:0] b;
    for (int r = 0; r < RATE; r++) begin
      b[r*DWIDTH +: DWIDTH] = word_value(tag, k * RATE + r);
    end
    return b;
  endfunction

  task automatic clear_ddr();
    for (int i = 0; i < NADDR; i++) begin
      ddr_written[i] = 1'b0;
    end
    ddr_beats = 0;
  endtask

  task automatic axi_write(input logic [AXI_AWIDTH-1:0] addr,
                           input logic [AXI_DWIDTH-1:0] data);
    int n;
    n = 0;
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wvalid  <= 1'b1;
    @(posedge clk);
    while (!(s_axi_awready && s_axi_wready)) begin
      n++;
      if (n == TIMEOUT) timed_out("AXI write address");
      @(posedge clk);
    end
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    n = 0;
    @(posedge clk);
    while (!s_axi_bvalid) begin
      n++;
      if (n == TIMEOUT) timed_out("AXI write response");
      @(posedge clk);
    end
    expect_equal("axi_write", "bresp", 32'h0, 32'(s_axi_bresp));
    // bready comes a cycle late, so bvalid has to wait.
    s_axi_bready <= 1'b1;
    @(posedge clk);
    s_axi_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_AWIDTH-1:0] addr,
                          output logic [AXI_DWIDTH-1:0] data, output logic [1:0] resp);
    int n;
    n = 0;
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    @(posedge clk);
    while (!s_axi_arready) begin
      n++;
      if (n == TIMEOUT) timed_out("AXI read address");
      @(posedge clk);
    end
    s_axi_arvalid <= 1'b0;
    n = 0;
    @(posedge clk);
    while (!s_axi_rvalid) begin
      n++;
      if (n == TIMEOUT) timed_out("AXI read data");
      @(posedge clk);
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
    s_axi_rready <= 1'b1;
    @(posedge clk);
    s_axi_rready <= 1'b0;
  endtask

  // offers words first..last-1, stops early after stall_stop idle cycles.
  task automatic send_words(input int tag, input int first, input int last,
                            input int stall_stop, output int sent);
    int idle;
    sent = 0;
    idle = 0;
    mem_we    <= 1'b1;
    mem_wdata <= word_value(tag, first);
    while (first + sent < last) begin
      @(posedge clk);
      if (mem_ready) begin
        sent++;
        idle = 0;
        mem_wdata <= word_value(tag, first + sent);
      end else begin
        idle++;
        if (stall_stop > 0 && idle == stall_stop) break;
        if (idle == TIMEOUT) timed_out("mem_ready");
      end
    end
    mem_we <= 1'b0;
  endtask

  task automatic wait_done(input string test);
    logic [31:0] st;
    logic [1:0]  resp;
    int          n;
    n = 0;
    axi_read(REG_STATUS, st, resp);
    while (!st[1]) begin
      n++;
      if (n == POLL_LIMIT) timed_out({test, " job done"});
      axi_read(REG_STATUS, st, resp);
    end
    expect_equal(test, "status at done", 32'h2, st);
  endtask

  task automatic start_job(input int base, input int len);
    axi_write(REG_BASE, base);
    axi_write(REG_LEN, len);
    axi_write(REG_CTRL, 32'h1);
  endtask

  // every beat at base+k, and no other write.
  task automatic check_job(input string test, input int tag, input int base, input int nwords);
    logic [MEMSIZE-1:0] a;
    expect_equal(test, "beat count", nwords / RATE, ddr_beats);
    for (int k = 0; k < nwords / RATE; k++) begin
      a = MEMSIZE'(base + k);
      assert (ddr_written[a]) else begin
        $display("%s: no DDR write at address %h", test, a);
        abort_run();
      end
      expect_equal(test, $sformatf("beat %0d", k), beat_value(tag, k), ddr_mem[a]);
    end
  endtask

  // ########################################################################
  // directed tests.
  // ########################################################################

  task automatic test_regs();
    logic [31:0] d;
    logic [1:0]  r;
    axi_read(REG_STATUS, d, r);
    expect_equal("test_regs", "status after reset", 32'h0, d);
    axi_write(REG_BASE, 32'hdead_1234);
    axi_write(REG_LEN, 32'h0000_00aa);
    axi_read(REG_BASE, d, r);
    expect_equal("test_regs", "base", 32'h1234, d);
    axi_read(REG_LEN, d, r);
    expect_equal("test_regs", "len", 32'h00aa, d);
    axi_read(8'h10, d, r);
    expect_equal("test_regs", "unmapped data", 32'h0, d);
    expect_equal("test_regs", "unmapped resp", 32'h0, 32'(r));
  endtask

  task automatic test_one_burst();
    int sent;
    clear_ddr();
    ready_mode <= READY_HIGH;
    start_job(32'h40, 16);
    send_words(1, 0, 16, 0, sent);
    wait_done("test_one_burst");
    check_job("test_one_burst", 1, 32'h40, 16);
  endtask

  task automatic test_multi_burst();
    int sent;
    clear_ddr();
    ready_mode <= READY_RAND;
    start_job(32'h100, 48);
    send_words(2, 0, 48, 0, sent);
    wait_done("test_multi_burst");
    check_job("test_multi_burst", 2, 32'h100, 48);
  endtask

  task automatic test_partial();
    int sent;
    clear_ddr();
    ready_mode <= READY_HIGH;
    start_job(32'h200, 6);
    send_words(3, 0, 6, 0, sent);
    wait_done("test_partial");
    check_job("test_partial", 3, 32'h200, 6);
  endtask

  // both banks fill, then the word stream stalls.
  task automatic test_backpressure();
    int sent;
    int rest;
    clear_ddr();
    ready_mode <= READY_LOW;
    start_job(32'h300, 48);
    send_words(4, 0, 48, 50, sent);
    expect_equal("test_backpressure", "words before stall", 2 * BURST_LEN * RATE, sent);
    expect_equal("test_backpressure", "beats while stalled", 32'h0, ddr_beats);
    ready_mode <= READY_RAND;
    send_words(4, sent, 48, 0, rest);
    wait_done("test_backpressure");
    check_job("test_backpressure", 4, 32'h300, 48);
  endtask

  task automatic test_restart();
    logic [31:0] d;
    logic [1:0]  r;
    int          sent;
    clear_ddr();
    ready_mode <= READY_HIGH;
    start_job(32'h400, 4);
    send_words(5, 0, 4, 0, sent);
    wait_done("test_restart");
    check_job("test_restart", 5, 32'h400, 4);
    clear_ddr();
    start_job(32'h500, 20);
    axi_read(REG_STATUS, d, r);
    expect_equal("test_restart", "status after restart", 32'h1, d);
    send_words(6, 0, 20, 0, sent);
    wait_done("test_restart");
    check_job("test_restart", 6, 32'h500, 20);
  endtask

  initial begin
    xrst          = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '1;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    mem_we        = 1'b0;
    mem_wdata     = '0;
    ddr_ready     = 1'b1;
    ready_mode    = READY_HIGH;
    clear_ddr();
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    test_regs();
    test_one_burst();
    test_multi_burst();
    test_partial();
    test_backpressure();
    test_restart();
    if (i_ninjin_ddr_buf.i_assert.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("protocol assertions failed %0d times", i_ninjin_ddr_buf.i_assert.fail_cnt);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- sources.f
ninjin_pkg.sv
ninjin_bank.sv
ninjin_ctrl_lite.sv
ninjin_pack.sv
ninjin_ddr_drain.sv
ninjin_ddr_buf.sv
tb_ninjin_ddr_buf_assert.sv
tb_ninjin_ddr_buf.sv

//--- Bender.yml
package:
  name: ninjin_ddr_buf

sources:
  - ninjin_pkg.sv
  - ninjin_bank.sv
  - ninjin_ctrl_lite.sv
  - ninjin_pack.sv
  - ninjin_ddr_drain.sv
  - ninjin_ddr_buf.sv
  - target: test
    files:
      - tb_ninjin_ddr_buf_assert.sv
      - tb_ninjin_ddr_buf.sv
